// ==== include/host_bridge_params.svh ====
`ifndef HOST_BRIDGE_PARAMS_SVH
`define HOST_BRIDGE_PARAMS_SVH

// ************************************************************
// Host message bridge sizing
// ************************************************************

// Bits per host message
`define MSG_WIDTH 32

// FIFO entries per path, powers of two
`define WR_FIFO_DEPTH 16
`define LOOP_FIFO_DEPTH 16
`define RD_FIFO_DEPTH 16

// All ones closes the read stream
`define END_MARKER {`MSG_WIDTH{1'b1}}

`endif

// ==== hdl/host_bridge_pkg.sv ====
`default_nettype none

`include "host_bridge_params.svh"

package host_bridge_pkg;

  // ************************************************************
  // Message and host channel types
  // ************************************************************

  // One host message word
  typedef logic [`MSG_WIDTH-1:0] msg_t;

  // Host write request, data qualified by wren
  typedef struct packed {
    logic wren;
    msg_t data;
  } host_wr_t;

  // Host facing read channel, data valid while empty is low
  typedef struct packed {
    logic empty;
    logic eof;
    msg_t data;
  } host_rd_t;

  // Router FSM
  typedef enum logic {
    ST_STREAM = 1'b0,
    ST_ENDED  = 1'b1
  } router_state_e;

endpackage

`default_nettype wire

// ==== hdl/msg_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module msg_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                  bus_clk,
  input  logic                  rst_n,
  input  logic                  push,
  input  host_bridge_pkg::msg_t push_data,
  input  logic                  pop,
  output host_bridge_pkg::msg_t pop_data,
  output logic                  full,
  output logic                  empty
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  host_bridge_pkg::msg_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] count_nxt;
  logic             do_push;
  logic             do_pop;

  // Requests past the limits are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Occupancy after this edge
  always_comb begin
    count_nxt = count;
    if (do_push && !do_pop) begin
      count_nxt = count + 1'b1;
    end else if (do_pop && !do_push) begin
      count_nxt = count - 1'b1;
    end
  end

  // ************************************************************
  // Pointers and flags
  // ************************************************************

  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count_nxt;
      full  <= (count_nxt == CNT_W'(DEPTH));
      empty <= (count_nxt == '0);
    end
  end

  // Storage
  always_ff @(posedge bus_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Show-ahead, head entry visible while not empty
  assign pop_data = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== hdl/msg_router.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "host_bridge_params.svh"

module msg_router (
  input  logic                  bus_clk,
  input  logic                  rst_n,
  // Host read channel open
  input  logic                  rd_open,
  // Write FIFO side
  input  logic                  src_empty,
  input  host_bridge_pkg::msg_t src_data,
  output logic                  src_pop,
  // Loopback FIFO side
  input  logic                  loop_full,
  output logic                  loop_push,
  // Read FIFO side
  input  logic                  rd_full,
  output logic                  rd_push,
  // Shared payload for both destinations
  output host_bridge_pkg::msg_t fwd_data,
  // End of read stream
  output logic                  rd_eof
);

  host_bridge_pkg::router_state_e state;
  host_bridge_pkg::router_state_e state_nxt;

  logic rd_en;
  logic loop_ready;
  logic rd_ready;
  logic move;
  logic is_marker;

  // ************************************************************
  // Move conditions
  // ************************************************************

  // Read copies only while streaming and the host listens
  assign rd_en = (state == host_bridge_pkg::ST_STREAM) && rd_open;

  assign loop_ready = !loop_full;

  // A disabled read path never holds things up
  assign rd_ready = !rd_en || !rd_full;

  // One message per cycle when every target can take it
  assign move = !src_empty && loop_ready && rd_ready;

  assign is_marker = (src_data == `END_MARKER);

  assign src_pop   = move;
  assign loop_push = move;
  assign rd_push   = move && rd_en;
  assign fwd_data  = src_data;

  // ************************************************************
  // Stream state
  // ************************************************************

  always_comb begin
    state_nxt = state;
    case (state)
      host_bridge_pkg::ST_STREAM: begin
        // Marker has reached the read FIFO
        if (rd_push && is_marker) begin
          state_nxt = host_bridge_pkg::ST_ENDED;
        end
      end
      host_bridge_pkg::ST_ENDED: begin
        // Host closing the read channel rearms the stream
        if (!rd_open) begin
          state_nxt = host_bridge_pkg::ST_STREAM;
        end
      end
      default: begin
        state_nxt = host_bridge_pkg::ST_STREAM;
      end
    endcase
  end

  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      state <= host_bridge_pkg::ST_STREAM;
    end else begin
      state <= state_nxt;
    end
  end

  assign rd_eof = (state == host_bridge_pkg::ST_ENDED);

endmodule

`default_nettype wire

// ==== hdl/stream_status.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_status (
  input  logic                      bus_clk,
  input  logic                      rst_n,
  input  host_bridge_pkg::host_wr_t wr,
  input  logic                      wr_full,
  input  logic                      wr_open,
  input  logic                      loop_empty,
  input  logic                      rd_eof,
  output logic                      loop_eof,
  output logic                      overflow,
  output logic [3:0]                led
);

  logic wr_accept;
  logic wr_drop;
  logic wr_data_seen;

  assign wr_accept = wr.wren && !wr_full;
  assign wr_drop   = wr.wren && wr_full;

  // ************************************************************
  // Loopback end of file and overflow
  // ************************************************************

  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      loop_eof     <= 1'b0;
      overflow     <= 1'b0;
      wr_data_seen <= 1'b0;
    end else begin
      // Writer gone and nothing left to read back
      loop_eof <= !wr_open && loop_empty;
      // Sticky, cleared by reset only
      if (wr_drop) begin
        overflow <= 1'b1;
      end
      // Write FIFO took a word this cycle
      wr_data_seen <= wr_accept;
    end
  end

  // LEDs, one register stage after their sources
  always_ff @(posedge bus_clk) begin
    if (!rst_n) begin
      led <= '0;
    end else begin
      led <= {rd_eof, loop_eof, overflow, wr_data_seen};
    end
  end

endmodule

`default_nettype wire

// ==== hdl/host_bridge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "host_bridge_params.svh"

module host_bridge_top (
  input  logic                      bus_clk,
  input  logic                      rst_n,
  // Host write channel
  input  host_bridge_pkg::host_wr_t wr,
  output logic                      wr_full,
  input  logic                      wr_open,
  // Host read channel
  output host_bridge_pkg::host_rd_t rd,
  input  logic                      rd_rden,
  input  logic                      rd_open,
  // Host loopback channel
  output host_bridge_pkg::host_rd_t loop,
  input  logic                      loop_rden,
  // Status
  output logic [3:0]                led
);

  host_bridge_pkg::msg_t src_data;
  host_bridge_pkg::msg_t fwd_data;
  host_bridge_pkg::msg_t rd_data;
  host_bridge_pkg::msg_t loop_data;

  logic src_pop;
  logic src_empty;
  logic loop_push;
  logic loop_full;
  logic loop_empty;
  logic loop_eof;
  logic rd_push;
  logic rd_full;
  logic rd_empty;
  logic rd_eof;

  // ************************************************************
  // Message FIFOs
  // ************************************************************

  msg_fifo #(.DEPTH(`WR_FIFO_DEPTH)) u_wr_fifo (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .push      (wr.wren),
    .push_data (wr.data),
    .pop       (src_pop),
    .pop_data  (src_data),
    .full      (wr_full),
    .empty     (src_empty)
  );

  msg_fifo #(.DEPTH(`LOOP_FIFO_DEPTH)) u_loop_fifo (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .push      (loop_push),
    .push_data (fwd_data),
    .pop       (loop_rden),
    .pop_data  (loop_data),
    .full      (loop_full),
    .empty     (loop_empty)
  );

  msg_fifo #(.DEPTH(`RD_FIFO_DEPTH)) u_rd_fifo (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .push      (rd_push),
    .push_data (fwd_data),
    .pop       (rd_rden),
    .pop_data  (rd_data),
    .full      (rd_full),
    .empty     (rd_empty)
  );

  // ************************************************************
  // Routing and status
  // ************************************************************

  msg_router u_msg_router (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .rd_open   (rd_open),
    .src_empty (src_empty),
    .src_data  (src_data),
    .src_pop   (src_pop),
    .loop_full (loop_full),
    .loop_push (loop_push),
    .rd_full   (rd_full),
    .rd_push   (rd_push),
    .fwd_data  (fwd_data),
    .rd_eof    (rd_eof)
  );

  // Overflow reaches the host through the LEDs only
  stream_status u_stream_status (
    .bus_clk    (bus_clk),
    .rst_n      (rst_n),
    .wr         (wr),
    .wr_full    (wr_full),
    .wr_open    (wr_open),
    .loop_empty (loop_empty),
    .rd_eof     (rd_eof),
    .loop_eof   (loop_eof),
    .overflow   (),
    .led        (led)
  );

  // Host channel bundles
  assign rd   = '{empty: rd_empty, eof: rd_eof, data: rd_data};
  assign loop = '{empty: loop_empty, eof: loop_eof, data: loop_data};

endmodule

`default_nettype wire

// ==== verification/host_bridge_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "host_bridge_params.svh"

module host_bridge_tb;

  localparam int WAIT_LIMIT   = 60;
  localparam int DRAIN_LIMIT  = 600;
  localparam int SEL_RD_EOF   = 0;
  localparam int SEL_LOOP_EOF = 1;
  localparam int SEL_OVERFLOW = 2;
  localparam int SEL_WR_LED   = 3;
  localparam int SEL_LOOP_LED = 4;

  logic                      bus_clk;
  logic                      rst_n;
  host_bridge_pkg::host_wr_t wr;
  logic                      wr_full;
  logic                      wr_open;
  host_bridge_pkg::host_rd_t rd;
  logic                      rd_rden;
  logic                      rd_open;
  host_bridge_pkg::host_rd_t loop;
  logic                      loop_rden;
  logic [3:0]                led;

  // Expected words per host channel in arrival order
  host_bridge_pkg::msg_t rd_q[$];
  host_bridge_pkg::msg_t loop_q[$];

  integer seed = 98;
  int     checks;
  int     mismatches;
  int     failures;

  host_bridge_top i_host_bridge_top (
    .bus_clk   (bus_clk),
    .rst_n     (rst_n),
    .wr        (wr),
    .wr_full   (wr_full),
    .wr_open   (wr_open),
    .rd        (rd),
    .rd_rden   (rd_rden),
    .rd_open   (rd_open),
    .loop      (loop),
    .loop_rden (loop_rden),
    .led       (led)
  );

  initial begin
    bus_clk = 1'b0;
    forever #5 bus_clk = ~bus_clk;
  end

  // ************************************************************
  // Helpers
  // ************************************************************

  function automatic host_bridge_pkg::msg_t next_msg();
    host_bridge_pkg::msg_t value;
    value = `END_MARKER;
    // The marker would end the read stream early
    while (value == `END_MARKER) begin
      value = $random(seed);
    end
    return value;
  endfunction

  function automatic logic status_bit(input int sel);
    case (sel)
      SEL_RD_EOF:   return rd.eof;
      SEL_LOOP_EOF: return loop.eof;
      SEL_WR_LED:   return led[0];
      SEL_LOOP_LED: return led[2];
      default:      return led[1];
    endcase
  endfunction

  task automatic check_value(input string what, input logic [`MSG_WIDTH-1:0] got,
                             input logic [`MSG_WIDTH-1:0] exp);
    checks++;
    assert (got === exp) else begin
      mismatches++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic wait_status(input int sel, input logic level, input string what);
    int cycles;
    cycles = 0;
    @(negedge bus_clk);
    while (status_bit(sel) !== level && cycles < WAIT_LIMIT) begin
      @(negedge bus_clk);
      cycles++;
    end
    checks++;
    assert (status_bit(sel) === level) else begin
      failures++;
      $display("Timed out at %0t ns waiting for %s", $time, what);
    end
  endtask

  // One write attempt over two cycles; the DUT drops a write made while full
  task automatic write_msg(input host_bridge_pkg::msg_t data, input bit to_rd,
                           output bit accepted);
    @(negedge bus_clk);
    accepted = !wr_full;
    @(posedge bus_clk);
    wr.wren <= 1'b1;
    wr.data <= data;
    @(posedge bus_clk);
    wr.wren <= 1'b0;
    if (accepted) begin
      loop_q.push_back(data);
      if (to_rd) begin
        rd_q.push_back(data);
      end
    end
  endtask

  task automatic write_block(input int count, input bit to_rd);
    bit accepted;
    for (int i = 0; i < count; i++) begin
      write_msg(next_msg(), to_rd, accepted);
      check_value("write accepted", accepted, 1'b1);
    end
  endtask

  task automatic take_word(input bit is_rd, input host_bridge_pkg::msg_t got);
    checks++;
    if (is_rd) begin
      assert (rd_q.size() != 0) else begin
        failures++;
        $display("Read channel gave word %h at %0t ns with none expected", got, $time);
      end
      if (rd_q.size() != 0) check_value("read data", got, rd_q.pop_front());
    end else begin
      assert (loop_q.size() != 0) else begin
        failures++;
        $display("Loopback gave word %h at %0t ns with none expected", got, $time);
      end
      if (loop_q.size() != 0) check_value("loopback data", got, loop_q.pop_front());
    end
  endtask

  // Reads both channels until every expected word has arrived
  task automatic drain_channels();
    int cycles;
    bit take_rd;
    bit take_loop;
    cycles = 0;
    while ((rd_q.size() != 0 || loop_q.size() != 0) && cycles < DRAIN_LIMIT) begin
      @(negedge bus_clk);
      cycles++;
      take_rd   = !rd.empty;
      take_loop = !loop.empty;
      if (take_rd) take_word(1'b1, rd.data);
      if (take_loop) take_word(1'b0, loop.data);
      if (take_rd || take_loop) begin
        @(posedge bus_clk);
        rd_rden   <= take_rd;
        loop_rden <= take_loop;
        @(posedge bus_clk);
        rd_rden   <= 1'b0;
        loop_rden <= 1'b0;
      end
    end
    checks++;
    assert (rd_q.size() == 0 && loop_q.size() == 0) else begin
      failures++;
      $display("Timed out draining, %0d read and %0d loopback words missing",
               rd_q.size(), loop_q.size());
    end
    // Nothing else may show up afterwards
    repeat (4) begin
      @(negedge bus_clk);
      check_value("rd.empty after drain", rd.empty, 1'b1);
      check_value("loop.empty after drain", loop.empty, 1'b1);
    end
  endtask

  // ************************************************************
  // Directed tests
  // ************************************************************

  task automatic test_reset_state();
    @(negedge bus_clk);
    check_value("rd.empty", rd.empty, 1'b1);
    check_value("loop.empty", loop.empty, 1'b1);
    check_value("rd.eof", rd.eof, 1'b0);
    check_value("loop.eof", loop.eof, 1'b0);
    check_value("wr_full", wr_full, 1'b0);
    check_value("led", led, 4'h0);
  endtask

  task automatic test_stream_both();
    write_block(10, 1'b1);
    // The last word passes through the write FIFO
    wait_status(SEL_WR_LED, 1'b1, "write FIFO LED after a write");
    drain_channels();
    check_value("write FIFO LED when idle", led[0], 1'b0);
  endtask

  task automatic test_loopback_only();
    @(posedge bus_clk);
    rd_open <= 1'b0;
    write_block(6, 1'b0);
    drain_channels();
    @(posedge bus_clk);
    rd_open <= 1'b1;
  endtask

  task automatic test_back_pressure();
    int capacity;
    int accepted_cnt;
    int attempts;
    bit accepted;
    // Each message takes a loopback and a read slot at once
    capacity = `WR_FIFO_DEPTH +
               ((`LOOP_FIFO_DEPTH < `RD_FIFO_DEPTH) ? `LOOP_FIFO_DEPTH : `RD_FIFO_DEPTH);
    accepted_cnt = 0;
    attempts = 0;
    accepted = 1'b1;
    @(negedge bus_clk);
    check_value("overflow led before fill", led[1], 1'b0);
    // The first attempt seen full is the extra, dropped write
    while (accepted && attempts < capacity + 8) begin
      write_msg(next_msg(), 1'b1, accepted);
      if (accepted) accepted_cnt++;
      attempts++;
    end
    check_value("accepted writes", accepted_cnt, capacity);
    @(negedge bus_clk);
    check_value("wr_full", wr_full, 1'b1);
    wait_status(SEL_OVERFLOW, 1'b1, "overflow LED");
    drain_channels();
  endtask

  task automatic test_end_of_stream();
    bit accepted;
    write_msg(`END_MARKER, 1'b1, accepted);
    check_value("marker accepted", accepted, 1'b1);
    drain_channels();
    wait_status(SEL_RD_EOF, 1'b1, "rd.eof after marker");
    check_value("eof led", led[3], 1'b1);
    write_block(4, 1'b0);
    drain_channels();
    check_value("rd.eof held", rd.eof, 1'b1);
    // Closing the read channel rearms the stream
    @(posedge bus_clk);
    rd_open <= 1'b0;
    wait_status(SEL_RD_EOF, 1'b0, "rd.eof to clear");
    @(posedge bus_clk);
    rd_open <= 1'b1;
    write_block(3, 1'b1);
    drain_channels();
  endtask

  task automatic test_loop_eof();
    @(posedge bus_clk);
    wr_open <= 1'b0;
    wait_status(SEL_LOOP_EOF, 1'b1, "loop.eof with writer closed");
    wait_status(SEL_LOOP_LED, 1'b1, "loop.eof LED to rise");
    @(posedge bus_clk);
    wr_open <= 1'b1;
    wait_status(SEL_LOOP_EOF, 1'b0, "loop.eof to clear");
    wait_status(SEL_LOOP_LED, 1'b0, "loop.eof LED to clear");
  endtask

  initial begin
    rst_n      = 1'b0;
    wr         = '0;
    wr_open    = 1'b1;
    rd_rden    = 1'b0;
    rd_open    = 1'b1;
    loop_rden  = 1'b0;
    checks     = 0;
    mismatches = 0;
    failures   = 0;
    repeat (8) @(posedge bus_clk);
    rst_n <= 1'b1;

    test_reset_state();
    test_stream_both();
    test_loopback_only();
    test_back_pressure();
    test_end_of_stream();
    test_loop_eof();

    $display("Checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
hdl/host_bridge_pkg.sv
hdl/msg_fifo.sv
hdl/msg_router.sv
hdl/stream_status.sv
hdl/host_bridge_top.sv
verification/host_bridge_tb.sv

// ==== Bender.yml ====
package:
  name: host_bridge

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/host_bridge_pkg.sv
      - hdl/msg_fifo.sv
      - hdl/msg_router.sv
      - hdl/stream_status.sv
      - hdl/host_bridge_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/host_bridge_tb.sv
